//--- Bender.yml
package:
  name: com_tracker

sources:
  - logic/com_tracker_pkg.sv
  - logic/pixel_reconstruct.sv
  - logic/channel_threshold.sv
  - logic/com_accumulator.sv
  - logic/com_divider.sv
  - logic/com_result_tx.sv
  - logic/com_tracker_top.sv
  - target: test
    files:
      - sim/com_tracker_chk.sv
      - sim/tb_com_tracker.sv

//--- logic/channel_threshold.sv
`timescale 1ns/1ps
`default_nettype none

module channel_threshold (
  input  wire                         clk_camera,
  input  wire                         sys_rst_pixel,
  input  wire                         pix_valid_i,
  input  com_tracker_pkg::pixel565_t  pix_data_i,
  input  com_tracker_pkg::hcount_t    pix_x_i,
  input  com_tracker_pkg::vcount_t    pix_y_i,
  input  wire                         frame_end_i,
  input  com_tracker_pkg::chan_sel_e  chan_sel_i,
  input  wire  [7:0]                  lower_i,
  input  wire  [7:0]                  upper_i,
  output logic                        mask_valid_o,
  output logic                        mask_o,
  output com_tracker_pkg::hcount_t    mask_x_o,
  output com_tracker_pkg::vcount_t    mask_y_o,
  output logic                        frame_end_o
);
  import com_tracker_pkg::*;

  logic [7:0]  red8;
  logic [7:0]  green8;
  logic [7:0]  blue8;
  logic [10:0] luma_sum;
  logic [7:0]  luma8;
  logic [7:0]  sel_val;

  always_comb begin
    // zero padding at the bottom of each field
    red8   = {pix_data_i[15:11], 3'b000};
    green8 = {pix_data_i[10:5], 2'b00};
    blue8  = {pix_data_i[4:0], 3'b000};
    // (2r + 5g + b) / 8, max 2004 fits 11 bits
    luma_sum = 11'(red8) * 11'd2 + 11'(green8) * 11'd5 + 11'(blue8);
    luma8    = luma_sum[10:3];
    sel_val  = luma8;
    case (chan_sel_i)
      CH_RED:   sel_val = red8;
      CH_GREEN: sel_val = green8;
      CH_BLUE:  sel_val = blue8;
      CH_LUMA:  sel_val = luma8;
      default:  sel_val = luma8;
    endcase
  end

  // valid and frame end move together, keeps frame_end behind the last pixel
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      mask_valid_o <= 1'b0;
      frame_end_o  <= 1'b0;
    end else begin
      mask_valid_o <= pix_valid_i;
      frame_end_o  <= frame_end_i;
    end
  end

  // inclusive window
  always_ff @(posedge clk_camera) begin
    mask_o   <= (sel_val >= lower_i) && (sel_val <= upper_i);
    mask_x_o <= pix_x_i;
    mask_y_o <= pix_y_i;
  end

endmodule

`default_nettype wire

//--- logic/com_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module com_accumulator #(
  parameter int SUM_X_W = 32,
  parameter int SUM_Y_W = 31
) (
  input  wire                        clk_camera,
  input  wire                        sys_rst_pixel,
  input  wire                        mask_valid_i,
  input  wire                        mask_i,
  input  com_tracker_pkg::hcount_t   mask_x_i,
  input  com_tracker_pkg::vcount_t   mask_y_i,
  input  wire                        frame_end_i,
  input  wire                        div_busy_i,
  output logic                       sums_valid_o,
  output logic [SUM_X_W-1:0]         sum_x_o,
  output logic [SUM_Y_W-1:0]         sum_y_o,
  output com_tracker_pkg::pix_cnt_t  count_o,
  output logic [7:0]                 frames_dropped_o
);
  import com_tracker_pkg::*;

  logic [SUM_X_W-1:0] acc_x;
  logic [SUM_Y_W-1:0] acc_y;
  pix_cnt_t           acc_cnt;
  logic               hand_off;

  // frame done and divider free to take it
  assign hand_off = frame_end_i & ~div_busy_i;

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      acc_x            <= '0;
      acc_y            <= '0;
      acc_cnt          <= '0;
      sums_valid_o     <= 1'b0;
      frames_dropped_o <= '0;
    end else begin
      sums_valid_o <= hand_off;
      if (frame_end_i) begin
        // start clean for the next frame
        acc_x   <= '0;
        acc_y   <= '0;
        acc_cnt <= '0;
        // divider still busy, this frame is lost
        if (div_busy_i && frames_dropped_o != 8'hff) begin
          frames_dropped_o <= frames_dropped_o + 1'b1;
        end
      end else if (mask_valid_i && mask_i) begin
        acc_x   <= acc_x + SUM_X_W'(mask_x_i);
        acc_y   <= acc_y + SUM_Y_W'(mask_y_i);
        acc_cnt <= acc_cnt + 1'b1;
      end
    end
  end

  // totals frozen for the divider
  always_ff @(posedge clk_camera) begin
    if (hand_off) begin
      sum_x_o <= acc_x;
      sum_y_o <= acc_y;
      count_o <= acc_cnt;
    end
  end

endmodule

`default_nettype wire

//--- logic/com_divider.sv
`timescale 1ns/1ps
`default_nettype none

module com_divider #(
  parameter int SUM_X_W = 32,
  parameter int SUM_Y_W = 31
) (
  input  wire                        clk_camera,
  input  wire                        sys_rst_pixel,
  input  wire                        sums_valid_i,
  input  wire  [SUM_X_W-1:0]         sum_x_i,
  input  wire  [SUM_Y_W-1:0]         sum_y_i,
  input  com_tracker_pkg::pix_cnt_t  count_i,
  input  wire                        res_full_i,
  output logic                       div_busy_o,
  output logic                       res_valid_o,
  output com_tracker_pkg::hcount_t   res_x_o,
  output com_tracker_pkg::vcount_t   res_y_o,
  output com_tracker_pkg::pix_cnt_t  res_count_o
);
  import com_tracker_pkg::*;

  // one shared datapath, wide enough for either dividend
  localparam int DIV_W = (SUM_X_W > SUM_Y_W) ? SUM_X_W : SUM_Y_W;
  localparam int CNT_W = $clog2(DIV_W + 1);

  div_state_e           state;
  logic [CNT_W-1:0]     bit_cnt;
  logic [DIV_W-1:0]     work;
  logic [PIX_CNT_W-1:0] rem;
  pix_cnt_t             divisor;
  logic [SUM_Y_W-1:0]   sum_y_hold;
  logic [PIX_CNT_W:0]   rem_shift;
  logic [PIX_CNT_W:0]   rem_diff;
  logic                 q_bit;
  logic [PIX_CNT_W-1:0] rem_next;
  logic [DIV_W-1:0]     work_next;

  // one restoring step, dividend msb into remainder, quotient bit into lsb
  always_comb begin
    rem_shift = {rem, work[DIV_W-1]};
    rem_diff  = rem_shift - {1'b0, divisor};
    // no borrow means the subtraction fits
    q_bit     = ~rem_diff[PIX_CNT_W];
    rem_next  = q_bit ? rem_diff[PIX_CNT_W-1:0] : rem_shift[PIX_CNT_W-1:0];
    work_next = {work[DIV_W-2:0], q_bit};
  end

  assign div_busy_o  = (state != DIV_IDLE);
  // offered while the tx stage is empty
  assign res_valid_o = (state == DIV_DONE) & ~res_full_i;

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      state <= DIV_IDLE;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (sums_valid_i) begin
            // empty mask skips straight to the result
            state <= (count_i == '0) ? DIV_DONE : DIV_X;
          end
        end
        DIV_X:    if (bit_cnt == CNT_W'(1)) state <= DIV_Y;
        DIV_Y:    if (bit_cnt == CNT_W'(1)) state <= DIV_DONE;
        DIV_DONE: if (!res_full_i) state <= DIV_IDLE;
        default:  state <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_camera) begin
    case (state)
      DIV_IDLE: begin
        divisor     <= count_i;
        res_count_o <= count_i;
        sum_y_hold  <= sum_y_i;
        res_x_o     <= '0;
        res_y_o     <= '0;
        // left aligned so the msb is shifted out first
        work        <= DIV_W'(sum_x_i) << (DIV_W - SUM_X_W);
        rem         <= '0;
        bit_cnt     <= CNT_W'(SUM_X_W);
      end
      DIV_X: begin
        if (bit_cnt == CNT_W'(1)) begin
          // mean x done, load y
          res_x_o <= work_next[HCOUNT_W-1:0];
          work    <= DIV_W'(sum_y_hold) << (DIV_W - SUM_Y_W);
          rem     <= '0;
          bit_cnt <= CNT_W'(SUM_Y_W);
        end else begin
          work    <= work_next;
          rem     <= rem_next;
          bit_cnt <= bit_cnt - 1'b1;
        end
      end
      DIV_Y: begin
        work    <= work_next;
        rem     <= rem_next;
        bit_cnt <= bit_cnt - 1'b1;
        if (bit_cnt == CNT_W'(1)) begin
          res_y_o <= work_next[VCOUNT_W-1:0];
        end
      end
      default: begin
        // DIV_DONE holds the result
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/com_result_tx.sv
`timescale 1ns/1ps
`default_nettype none

module com_result_tx #(
  parameter int INIT_CREDITS = 2
) (
  input  wire                        clk_camera,
  input  wire                        sys_rst_pixel,
  input  wire                        res_valid_i,
  input  com_tracker_pkg::hcount_t   res_x_i,
  input  com_tracker_pkg::vcount_t   res_y_i,
  input  com_tracker_pkg::pix_cnt_t  res_count_i,
  input  wire                        credit_return_i,
  output logic                       res_full_o,
  output logic                       com_valid_o,
  output com_tracker_pkg::hcount_t   com_x_o,
  output com_tracker_pkg::vcount_t   com_y_o,
  output com_tracker_pkg::pix_cnt_t  com_pixels_o
);

  localparam int CRED_W = $clog2(INIT_CREDITS + 1);

  logic              full;
  logic [CRED_W-1:0] credit_cnt;

  assign res_full_o  = full;
  // send whenever a result is held and a credit is left
  assign com_valid_o = full & (credit_cnt != '0);

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      full       <= 1'b0;
      credit_cnt <= CRED_W'(INIT_CREDITS);
    end else begin
      // load only when empty, clear after the send cycle
      if (com_valid_o) begin
        full <= 1'b0;
      end else if (res_valid_i) begin
        full <= 1'b1;
      end
      case ({com_valid_o, credit_return_i})
        2'b10: credit_cnt <= credit_cnt - 1'b1;
        2'b01: begin
          // capped at the reset value
          if (credit_cnt != CRED_W'(INIT_CREDITS)) begin
            credit_cnt <= credit_cnt + 1'b1;
          end
        end
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // one-entry holding register
  always_ff @(posedge clk_camera) begin
    if (res_valid_i && !full) begin
      com_x_o      <= res_x_i;
      com_y_o      <= res_y_i;
      com_pixels_o <= res_count_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/com_tracker_pkg.sv
`default_nettype none

package com_tracker_pkg;

  // camera raster counters
  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;

  typedef logic [HCOUNT_W-1:0] hcount_t;
  typedef logic [VCOUNT_W-1:0] vcount_t;

  // rgb565 pixel
  // red [15:11], green [10:5], blue [4:0]
  typedef logic [15:0] pixel565_t;

  // channel fed to the threshold compare
  typedef enum logic [1:0] {
    CH_RED   = 2'd0,
    CH_GREEN = 2'd1,
    CH_BLUE  = 2'd2,
    // weighted sum of r, g, b
    CH_LUMA  = 2'd3
  } chan_sel_e;

  // number of masked pixels in one frame
  localparam int PIX_CNT_W = 21;

  typedef logic [PIX_CNT_W-1:0] pix_cnt_t;

  // divider sequencing
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    // mean x first, then mean y
    DIV_X    = 2'd1,
    DIV_Y    = 2'd2,
    // result waits here until the tx stage takes it
    DIV_DONE = 2'd3
  } div_state_e;

endpackage

`default_nettype wire

//--- logic/com_tracker_top.sv
`timescale 1ns/1ps
`default_nettype none

module com_tracker_top #(
  parameter int INIT_CREDITS = 2,
  parameter int SUM_X_W      = 32,
  parameter int SUM_Y_W      = 31
) (
  input  wire                        clk_camera,
  input  wire                        sys_rst_pixel,
  input  wire  [7:0]                 camera_d_i,
  input  wire                        cam_pclk_i,
  input  wire                        cam_hsync_i,
  input  wire                        cam_vsync_i,
  input  com_tracker_pkg::chan_sel_e chan_sel_i,
  input  wire  [7:0]                 lower_i,
  input  wire  [7:0]                 upper_i,
  input  wire                        credit_return_i,
  output logic                       com_valid_o,
  output com_tracker_pkg::hcount_t   com_x_o,
  output com_tracker_pkg::vcount_t   com_y_o,
  output com_tracker_pkg::pix_cnt_t  com_pixels_o,
  output logic [7:0]                 frames_dropped_o
);
  import com_tracker_pkg::*;

  // camera to threshold
  logic               pix_valid;
  pixel565_t          pix_data;
  hcount_t            pix_x;
  vcount_t            pix_y;
  logic               pix_frame_end;
  // threshold to accumulator
  logic               mask_valid;
  logic               mask;
  hcount_t            mask_x;
  vcount_t            mask_y;
  logic               mask_frame_end;
  // accumulator to divider
  logic               sums_valid;
  logic [SUM_X_W-1:0] sum_x;
  logic [SUM_Y_W-1:0] sum_y;
  pix_cnt_t           sum_count;
  logic               div_busy;
  // divider to tx
  logic               res_valid;
  hcount_t            res_x;
  vcount_t            res_y;
  pix_cnt_t           res_count;
  logic               res_full;

  pixel_reconstruct u_reconstruct (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .camera_d_i    (camera_d_i),
    .cam_pclk_i    (cam_pclk_i),
    .cam_hsync_i   (cam_hsync_i),
    .cam_vsync_i   (cam_vsync_i),
    .pix_valid_o   (pix_valid),
    .pix_data_o    (pix_data),
    .pix_x_o       (pix_x),
    .pix_y_o       (pix_y),
    .frame_end_o   (pix_frame_end)
  );

  channel_threshold u_threshold (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .pix_valid_i   (pix_valid),
    .pix_data_i    (pix_data),
    .pix_x_i       (pix_x),
    .pix_y_i       (pix_y),
    .frame_end_i   (pix_frame_end),
    .chan_sel_i    (chan_sel_i),
    .lower_i       (lower_i),
    .upper_i       (upper_i),
    .mask_valid_o  (mask_valid),
    .mask_o        (mask),
    .mask_x_o      (mask_x),
    .mask_y_o      (mask_y),
    .frame_end_o   (mask_frame_end)
  );

  com_accumulator #(
    .SUM_X_W (SUM_X_W),
    .SUM_Y_W (SUM_Y_W)
  ) u_accum (
    .clk_camera       (clk_camera),
    .sys_rst_pixel    (sys_rst_pixel),
    .mask_valid_i     (mask_valid),
    .mask_i           (mask),
    .mask_x_i         (mask_x),
    .mask_y_i         (mask_y),
    .frame_end_i      (mask_frame_end),
    .div_busy_i       (div_busy),
    .sums_valid_o     (sums_valid),
    .sum_x_o          (sum_x),
    .sum_y_o          (sum_y),
    .count_o          (sum_count),
    .frames_dropped_o (frames_dropped_o)
  );

  com_divider #(
    .SUM_X_W (SUM_X_W),
    .SUM_Y_W (SUM_Y_W)
  ) u_divider (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .sums_valid_i  (sums_valid),
    .sum_x_i       (sum_x),
    .sum_y_i       (sum_y),
    .count_i       (sum_count),
    .res_full_i    (res_full),
    .div_busy_o    (div_busy),
    .res_valid_o   (res_valid),
    .res_x_o       (res_x),
    .res_y_o       (res_y),
    .res_count_o   (res_count)
  );

  com_result_tx #(
    .INIT_CREDITS (INIT_CREDITS)
  ) u_tx (
    .clk_camera      (clk_camera),
    .sys_rst_pixel   (sys_rst_pixel),
    .res_valid_i     (res_valid),
    .res_x_i         (res_x),
    .res_y_i         (res_y),
    .res_count_i     (res_count),
    .credit_return_i (credit_return_i),
    .res_full_o      (res_full),
    .com_valid_o     (com_valid_o),
    .com_x_o         (com_x_o),
    .com_y_o         (com_y_o),
    .com_pixels_o    (com_pixels_o)
  );

endmodule

`default_nettype wire

//--- logic/pixel_reconstruct.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_reconstruct (
  input  wire                         clk_camera,
  input  wire                         sys_rst_pixel,
  input  wire  [7:0]                  camera_d_i,
  input  wire                         cam_pclk_i,
  input  wire                         cam_hsync_i,
  input  wire                         cam_vsync_i,
  output logic                        pix_valid_o,
  output com_tracker_pkg::pixel565_t  pix_data_o,
  output com_tracker_pkg::hcount_t    pix_x_o,
  output com_tracker_pkg::vcount_t    pix_y_o,
  output logic                        frame_end_o
);
  import com_tracker_pkg::*;

  // camera bus packed as {d, pclk, hsync, vsync}
  localparam int SYNC_W = 11;

  logic [SYNC_W-1:0] sync_q1;
  logic [SYNC_W-1:0] sync_q2;
  logic [7:0]        cam_d_s;
  logic              pclk_s;
  logic              hs_s;
  logic              vs_s;
  logic              pclk_q;
  logic              hs_q;
  logic              vs_q;
  logic              pclk_rise;
  logic              hs_fall;
  logic              vs_fall;
  logic              take_byte;
  logic              byte_phase;
  logic [7:0]        hi_byte;
  hcount_t           col_cnt;
  vcount_t           row_cnt;

  // two-flop synchroniser, all camera lines together
  always_ff @(posedge clk_camera) begin
    sync_q1 <= {camera_d_i, cam_pclk_i, cam_hsync_i, cam_vsync_i};
    sync_q2 <= sync_q1;
  end

  assign cam_d_s = sync_q2[10:3];
  assign pclk_s  = sync_q2[2];
  assign hs_s    = sync_q2[1];
  assign vs_s    = sync_q2[0];

  // edges against the previous synchronised sample
  assign pclk_rise = pclk_s & ~pclk_q;
  assign hs_fall   = hs_q & ~hs_s;
  assign vs_fall   = vs_q & ~vs_s;
  // only bytes inside an active line of an active frame
  assign take_byte = pclk_rise & hs_s & vs_s;

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      pclk_q      <= 1'b0;
      hs_q        <= 1'b0;
      vs_q        <= 1'b0;
      byte_phase  <= 1'b0;
      col_cnt     <= '0;
      row_cnt     <= '0;
      pix_valid_o <= 1'b0;
      frame_end_o <= 1'b0;
    end else begin
      pclk_q      <= pclk_s;
      hs_q        <= hs_s;
      vs_q        <= vs_s;
      pix_valid_o <= 1'b0;
      frame_end_o <= vs_fall;
      // column and byte pairing restart with every line
      if (!hs_s) begin
        col_cnt    <= '0;
        byte_phase <= 1'b0;
      end else if (take_byte) begin
        byte_phase <= ~byte_phase;
        // second byte completes the pixel
        if (byte_phase) begin
          pix_valid_o <= 1'b1;
          col_cnt     <= col_cnt + 1'b1;
        end
      end
      // rows count hsync falls, held at 0 outside the frame
      if (!vs_s) begin
        row_cnt <= '0;
      end else if (hs_fall) begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

  // pixel payload
  always_ff @(posedge clk_camera) begin
    if (take_byte) begin
      if (!byte_phase) begin
        // high byte arrives first
        hi_byte <= cam_d_s;
      end else begin
        pix_data_o <= {hi_byte, cam_d_s};
        pix_x_o    <= col_cnt;
        pix_y_o    <= row_cnt;
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/com_tracker_chk.sv
`timescale 1ns/1ps
`default_nettype none

module com_tracker_chk #(
  parameter int INIT_CREDITS = 2
) (
  input wire                                  clk_camera,
  input wire                                  sys_rst_pixel,
  input wire                                  com_valid_i,
  input wire                                  credit_return_i,
  input wire [$clog2(INIT_CREDITS + 1)-1:0]   credit_cnt_i
);

  // failure tallies summed into one count
  int n_no_credit = 0;
  int n_double    = 0;
  int n_over      = 0;
  int fail_cnt;
  // credits the consumer still grants, rebuilt from the port pulses
  int credits_left;
  int credits_after_send;

  assign fail_cnt = n_no_credit + n_double + n_over;
  assign credits_after_send = credits_left - (com_valid_i ? 1 : 0);

  // each return adds one, capped at the reset value
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      credits_left <= INIT_CREDITS;
    end else if (credit_return_i && credits_after_send < INIT_CREDITS) begin
      credits_left <= credits_after_send + 1;
    end else begin
      credits_left <= credits_after_send;
    end
  end

  // a send needs a credit granted by the consumer
  a_no_credit: assert property (
    @(posedge clk_camera) disable iff (sys_rst_pixel)
    com_valid_i |-> (credits_left > 0)
  ) else begin
    n_no_credit++;
    $error("com_valid_o high with no credit left");
  end

  // single-cycle send pulse
  a_one_cycle: assert property (
    @(posedge clk_camera) disable iff (sys_rst_pixel)
    com_valid_i |=> !com_valid_i
  ) else begin
    n_double++;
    $error("com_valid_o high for two cycles in a row");
  end

  // returns never push the count past the reset value
  a_credit_cap: assert property (
    @(posedge clk_camera) disable iff (sys_rst_pixel)
    credit_cnt_i <= INIT_CREDITS
  ) else begin
    n_over++;
    $error("credit count above INIT_CREDITS");
  end

endmodule

`default_nettype wire

//--- sim/com_tracker_testdata.txt
// chan lower upper bg x0 y0 x1 y1 rect credit_mode exp_x exp_y exp_pixels (all hex)
// chan 0 red 1 green 2 blue 3 luma, f ends the list; credit_mode 0 returns, 1 keeps
0 80 ff 0000 04 02 09 05 f800 0 006 003 000018
1 f0 ff 0000 0a 08 0d 0b 07e0 0 00b 009 000010
3 f0 ff 0000 0a 08 0d 0b 07e0 0 000 000 000000
3 90 a0 0000 0a 08 0d 0b 07e0 0 00b 009 000010
3 fa fa 001f 00 00 1f 00 ffff 0 00f 000 000020
2 10 40 f800 14 0c 1f 0f 0005 0 019 00d 000030
0 10 20 0000 00 00 00 00 f800 0 000 000 000000
// credits withheld from here on
0 80 ff 0000 04 02 09 05 f800 1 006 003 000018
2 10 40 f800 14 0c 1f 0f 0005 1 019 00d 000030
1 f0 ff 0000 0a 08 0d 0b 07e0 1 00b 009 000010
0 80 ff 0000 04 02 09 05 f800 1 006 003 000018
2 10 40 f800 14 0c 1f 0f 0005 1 019 00d 000030
3 fa fa 001f 00 00 1f 00 ffff 1 00f 000 000020
f 00 00 0000 00 00 00 00 0000 0 000 000 000000

//--- sim/tb_com_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_com_tracker;
  import com_tracker_pkg::*;

  localparam int INIT_CREDITS = 2;
  localparam int SUM_X_W      = 32;
  localparam int SUM_Y_W      = 31;
  // test frame geometry with one byte per 4-clock pclk period
  localparam int COLS    = 32;
  localparam int ROWS    = 16;
  localparam int H_BLANK = 8;
  localparam int V_FRONT = 8;
  // long enough for the divider to finish inside the blanking
  localparam int V_BLANK = 160;
  // words per record in the test data
  localparam int REC_W      = 13;
  localparam int MAX_FRAMES = 24;

  logic       clk_camera = 1'b0;
  logic       sys_rst_pixel;
  logic [7:0] camera_d;
  logic       cam_pclk;
  logic       cam_hsync;
  logic       cam_vsync;
  chan_sel_e  chan_sel;
  logic [7:0] lower;
  logic [7:0] upper;
  logic       credit_return;
  logic       com_valid;
  hcount_t    com_x;
  vcount_t    com_y;
  pix_cnt_t   com_pixels;
  logic [7:0] frames_dropped;

  logic [31:0] tdata [0:REC_W*MAX_FRAMES-1];
  int n_frames;
  int cycle_cnt = 0;
  int cycle_limit = 0;
  int frames_ended = 0;
  int credits;
  int exp_dropped;
  // results owed by the DUT in frame order
  hcount_t  exp_x_q[$];
  vcount_t  exp_y_q[$];
  pix_cnt_t exp_c_q[$];
  // results seen on the output
  hcount_t  got_x_q[$];
  vcount_t  got_y_q[$];
  pix_cnt_t got_c_q[$];

  com_tracker_top #(
    .INIT_CREDITS (INIT_CREDITS),
    .SUM_X_W      (SUM_X_W),
    .SUM_Y_W      (SUM_Y_W)
  ) u_dut (
    .clk_camera       (clk_camera),
    .sys_rst_pixel    (sys_rst_pixel),
    .camera_d_i       (camera_d),
    .cam_pclk_i       (cam_pclk),
    .cam_hsync_i      (cam_hsync),
    .cam_vsync_i      (cam_vsync),
    .chan_sel_i       (chan_sel),
    .lower_i          (lower),
    .upper_i          (upper),
    .credit_return_i  (credit_return),
    .com_valid_o      (com_valid),
    .com_x_o          (com_x),
    .com_y_o          (com_y),
    .com_pixels_o     (com_pixels),
    .frames_dropped_o (frames_dropped)
  );

  // credit rules checked inside the tx stage
  bind com_result_tx com_tracker_chk #(
    .INIT_CREDITS (INIT_CREDITS)
  ) u_chk (
    .clk_camera      (clk_camera),
    .sys_rst_pixel   (sys_rst_pixel),
    .com_valid_i     (com_valid_o),
    .credit_return_i (credit_return_i),
    .credit_cnt_i    (credit_cnt)
  );

  always #20 clk_camera = ~clk_camera;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_x(input hcount_t got, input hcount_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: com_x_o got %0d, expected %0d", $time, got, exp));
    end
  endtask

  task automatic check_y(input vcount_t got, input vcount_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: com_y_o got %0d, expected %0d", $time, got, exp));
    end
  endtask

  task automatic check_pixels(input pix_cnt_t got, input pix_cnt_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: com_pixels_o got %0d, expected %0d",
                         $time, got, exp));
    end
  endtask

  task automatic check_dropped(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: frames_dropped_o got %0d, expected %0d",
                         $time, got, exp));
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: com_valid_o got %b, expected %b",
                         $time, got, exp));
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk_camera);
  endtask

  // data set up with pclk low and the rising edge two clocks later
  task automatic send_byte(input logic [7:0] b);
    @(posedge clk_camera);
    camera_d <= b;
    cam_pclk <= 1'b0;
    @(posedge clk_camera);
    @(posedge clk_camera);
    cam_pclk <= 1'b1;
    @(posedge clk_camera);
  endtask

  // flat background with one filled rectangle with inclusive corners
  task automatic send_frame(input pixel565_t bg, input pixel565_t fg,
                            input int x0, input int y0, input int x1, input int y1);
    pixel565_t px;
    @(posedge clk_camera);
    cam_vsync <= 1'b1;
    idle(V_FRONT);
    for (int y = 0; y < ROWS; y++) begin
      @(posedge clk_camera);
      cam_hsync <= 1'b1;
      for (int x = 0; x < COLS; x++) begin
        px = (x >= x0 && x <= x1 && y >= y0 && y <= y1) ? fg : bg;
        // high byte first
        send_byte(px[15:8]);
        send_byte(px[7:0]);
      end
      @(posedge clk_camera);
      cam_hsync <= 1'b0;
      cam_pclk  <= 1'b0;
      idle(H_BLANK);
    end
    @(posedge clk_camera);
    cam_vsync <= 1'b0;
    frames_ended++;
  endtask

  // one pulse on the credit line, count capped like the consumer sees it
  task automatic return_credit();
    @(posedge clk_camera);
    credit_return <= 1'b1;
    @(posedge clk_camera);
    credit_return <= 1'b0;
    if (credits < INIT_CREDITS) credits++;
  endtask

  // next delivered result against the oldest one owed
  task automatic take_result();
    while (got_x_q.size() == 0) @(posedge clk_camera);
    check_x(got_x_q.pop_front(), exp_x_q.pop_front());
    check_y(got_y_q.pop_front(), exp_y_q.pop_front());
    check_pixels(got_c_q.pop_front(), exp_c_q.pop_front());
    credits--;
  endtask

  task automatic run_frame(input int idx);
    int b;
    int mode;
    b = idx * REC_W;
    mode = tdata[b+9];
    @(posedge clk_camera);
    chan_sel <= chan_sel_e'(tdata[b][1:0]);
    lower    <= tdata[b+1][7:0];
    upper    <= tdata[b+2][7:0];
    send_frame(tdata[b+3][15:0], tdata[b+8][15:0], tdata[b+4], tdata[b+5],
               tdata[b+6], tdata[b+7]);
    // frame is lost while tx holding register and divider are both occupied
    if (exp_x_q.size() >= 2) begin
      if (exp_dropped < 255) exp_dropped++;
    end else begin
      exp_x_q.push_back(hcount_t'(tdata[b+10]));
      exp_y_q.push_back(vcount_t'(tdata[b+11]));
      exp_c_q.push_back(pix_cnt_t'(tdata[b+12]));
    end
    idle(V_BLANK);
    @(negedge clk_camera);
    check_dropped(frames_dropped, 8'(exp_dropped));
    if (credits > 0 && exp_x_q.size() > 0) begin
      take_result();
      // mode 0 hands the credit straight back
      if (mode == 0) return_credit();
    end
    if (got_x_q.size() != 0) begin
      fail_run("a result came out although no credit was left for it");
    end
  endtask

  // output monitor sampled mid-cycle
  always @(negedge clk_camera) begin
    if (!sys_rst_pixel && u_dut.u_tx.u_chk.fail_cnt != 0) begin
      fail_run("an assertion on the result credit rules failed");
    end
    if (!sys_rst_pixel && com_valid === 1'b1) begin
      if (frames_ended == 0) begin
        fail_run("com_valid_o went high before any frame had ended");
      end
      got_x_q.push_back(com_x);
      got_y_q.push_back(com_y);
      got_c_q.push_back(com_pixels);
    end
  end

  always @(posedge clk_camera) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      fail_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    int frame_cycles;
    int div_cycles;
    sys_rst_pixel <= 1'b1;
    camera_d      <= 8'h00;
    cam_pclk      <= 1'b0;
    cam_hsync     <= 1'b0;
    cam_vsync     <= 1'b0;
    chan_sel      <= CH_RED;
    lower         <= 8'h00;
    upper         <= 8'h00;
    credit_return <= 1'b0;
    $readmemh("sim/com_tracker_testdata.txt", tdata);
    // records end at a channel word of f
    n_frames = 0;
    while (n_frames < MAX_FRAMES && tdata[n_frames*REC_W] != 32'hf) n_frames++;
    frame_cycles = V_FRONT + 2 + ROWS * (COLS * 8 + 2 + H_BLANK) + V_BLANK;
    div_cycles   = SUM_X_W + SUM_Y_W + 16;
    // two spare frames cover reset and the final release
    cycle_limit  = 2 * ((n_frames + 2) * (frame_cycles + div_cycles) + 16);
    credits      = INIT_CREDITS;
    exp_dropped  = 0;
    if (n_frames == 0) begin
      fail_run("no frame records found in the test data file");
    end
    repeat (3) @(posedge clk_camera);
    sys_rst_pixel <= 1'b0;
    @(negedge clk_camera);
    check_valid(com_valid, 1'b0);
    check_dropped(frames_dropped, 8'd0);
    // a return while all credits are held must leave the count at its cap
    return_credit();
    for (int i = 0; i < n_frames; i++) begin
      run_frame(i);
    end
    // each returned credit frees one held result
    while (exp_x_q.size() > 0) begin
      return_credit();
      take_result();
    end
    @(negedge clk_camera);
    check_dropped(frames_dropped, 8'(exp_dropped));
    if (got_x_q.size() == 0 && u_dut.u_tx.u_chk.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      fail_run("extra result or assertion failure found at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/com_tracker_pkg.sv
logic/pixel_reconstruct.sv
logic/channel_threshold.sv
logic/com_accumulator.sv
logic/com_divider.sv
logic/com_result_tx.sv
logic/com_tracker_top.sv
sim/com_tracker_chk.sv
sim/tb_com_tracker.sv
